// File: design/rv_isa_pkg.sv
package rv_isa_pkg;

    localparam int xlen = 32;

    typedef enum logic [6:0] {
        op_op     = 7'b0110011,
        op_imm    = 7'b0010011,
        op_lui    = 7'b0110111,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_branch = 7'b1100011,
        op_jal    = 7'b1101111
    } opcode_e;

    localparam logic [2:0] f3_add = 3'b000; // ADD/SUB, ADDI
    localparam logic [2:0] f3_slt = 3'b010;
    localparam logic [2:0] f3_xor = 3'b100;
    localparam logic [2:0] f3_or  = 3'b110;
    localparam logic [2:0] f3_and = 3'b111;
    localparam logic [2:0] f3_bne = 3'b001;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_slt, alu_pass_b
    } alu_op_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_e     opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        opcode_e    opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        opcode_e    opcode;
    } b_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        opcode_e    opcode;
    } j_fmt_t;

    // Same 32-bit word, one view per encoding
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        j_fmt_t j;
    } rv_inst_u;

endpackage

// File: design/rv_pipe_pkg.sv
package rv_pipe_pkg;
    import rv_isa_pkg::*;

    localparam int pc_width        = 12; // Byte address
    localparam int pred_index_bits = 4;

    localparam logic [1:0] wb_alu = 2'd0;
    localparam logic [1:0] wb_mem = 2'd1;
    localparam logic [1:0] wb_pc4 = 2'd2;

    typedef struct packed {
        logic       reg_write;
        logic       mem_read;
        logic       mem_write;
        logic       branch;
        logic       jump;
        logic       alu_src;
        alu_op_e    alu_op;
        logic [1:0] wb_sel;
    } ctrl_t;

    typedef enum logic [1:0] {fwd_none, fwd_ex_mem, fwd_mem_wb} fwd_sel_e;

    typedef struct packed {
        logic [pc_width-1:0] pc;
        rv_inst_u            inst;
    } if_id_t;

    typedef struct packed {
        logic [pc_width-1:0] pc;
        logic [xlen-1:0]     rs1_val;
        logic [xlen-1:0]     rs2_val;
        logic [xlen-1:0]     imm;
        logic [4:0]          rs1;
        logic [4:0]          rs2;
        logic [4:0]          rd;
        logic [2:0]          funct3;
        logic                pred_taken;
        logic [pc_width-1:0] pred_target; // pc + imm, also the real target
        ctrl_t               ctrl;
    } id_ex_t;

    typedef struct packed {
        logic [xlen-1:0] alu_result; // PC+4 already folded in for JAL
        logic [xlen-1:0] store_data;
        logic [4:0]      rd;
        ctrl_t           ctrl;
    } ex_mem_t;

    typedef struct packed {
        logic [xlen-1:0] alu_result;
        logic [xlen-1:0] mem_data;
        logic [4:0]      rd;
        ctrl_t           ctrl;
    } mem_wb_t;

endpackage

// File: design/rv_decoder.sv
module rv_decoder
    import rv_isa_pkg::*, rv_pipe_pkg::*;
(
    input  rv_inst_u        inst,
    output ctrl_t           ctrl,
    output logic [xlen-1:0] imm
);

    function automatic alu_op_e alu_from_funct(input logic [2:0] f3, input logic sub);
        case (f3)
            f3_add:  return sub ? alu_sub : alu_add;
            f3_slt:  return alu_slt;
            f3_xor:  return alu_xor;
            f3_or:   return alu_or;
            f3_and:  return alu_and;
            default: return alu_add;
        endcase
    endfunction

    always_comb begin
        ctrl = '0;
        imm  = '0;
        case (inst.r.opcode)
            op_op: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = alu_from_funct(inst.r.funct3, inst.r.funct7[5]);
                ctrl.wb_sel    = wb_alu;
            end
            op_imm: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = alu_from_funct(inst.i.funct3, 1'b0); // No SUBI
                imm = {{20{inst.i.imm_11_0[11]}}, inst.i.imm_11_0};
            end
            op_lui: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = alu_pass_b;
                imm = {inst.r.funct7, inst.r.rs2, inst.r.rs1, inst.r.funct3, 12'b0};
            end
            op_load: begin
                ctrl.reg_write = 1'b1;
                ctrl.mem_read  = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = alu_add;
                ctrl.wb_sel    = wb_mem;
                imm = {{20{inst.i.imm_11_0[11]}}, inst.i.imm_11_0};
            end
            op_store: begin
                ctrl.mem_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = alu_add;
                imm = {{20{inst.s.imm_11_5[6]}}, inst.s.imm_11_5, inst.s.imm_4_0};
            end
            op_branch: begin
                ctrl.branch = 1'b1;
                ctrl.alu_op = alu_sub; // Compare through zero flag
                imm = {{19{inst.b.imm_12}}, inst.b.imm_12, inst.b.imm_11,
                       inst.b.imm_10_5, inst.b.imm_4_1, 1'b0};
            end
            op_jal: begin
                ctrl.reg_write = 1'b1;
                ctrl.jump      = 1'b1;
                ctrl.wb_sel    = wb_pc4;
                imm = {{11{inst.j.imm_20}}, inst.j.imm_20, inst.j.imm_19_12,
                       inst.j.imm_11, inst.j.imm_10_1, 1'b0};
            end
            default: ; // Unknown opcode becomes a bubble
        endcase

        if (inst.r.rd == 5'd0)
            ctrl.reg_write = 1'b0;
    end

endmodule

// File: design/rv_regfile.sv
module rv_regfile
    import rv_isa_pkg::*;
(
    input  logic            CLK,
    input  logic            RESET_N,
    input  logic [4:0]      rs1,
    input  logic [4:0]      rs2,
    input  logic [4:0]      rd,
    input  logic [xlen-1:0] wdata,
    input  logic            we,
    output logic [xlen-1:0] rdata1,
    output logic [xlen-1:0] rdata2
);

    logic [xlen-1:0] regs [1:31];

    // Write-first, so a value in writeback is seen by decode directly
    function automatic logic [xlen-1:0] read_port(input logic [4:0] sel);
        if (sel == 5'd0)
            return '0;
        if (we && sel == rd)
            return wdata;
        return regs[sel];
    endfunction

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end else if (we && rd != 5'd0) begin
            regs[rd] <= wdata;
        end
    end

    always_comb begin
        rdata1 = read_port(rs1);
        rdata2 = read_port(rs2);
    end

endmodule

// File: design/rv_alu.sv
module rv_alu
    import rv_isa_pkg::*;
(
    input  logic [xlen-1:0] a,
    input  logic [xlen-1:0] b,
    input  alu_op_e         op,
    output logic [xlen-1:0] result,
    output logic            zero
);

    always_comb begin
        case (op)
            alu_add:    result = a + b;
            alu_sub:    result = a - b;
            alu_and:    result = a & b;
            alu_or:     result = a | b;
            alu_xor:    result = a ^ b;
            alu_slt:    result = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
            alu_pass_b: result = b; // LUI
            default:    result = '0;
        endcase
    end

    assign zero = (result == '0);

endmodule

// File: design/rv_hazard_unit.sv
module rv_hazard_unit
    import rv_pipe_pkg::*;
(
    input  logic [4:0] id_rs1,
    input  logic [4:0] id_rs2,
    input  logic [4:0] ex_rs1,
    input  logic [4:0] ex_rs2,
    input  logic [4:0] ex_rd,
    input  logic       ex_mem_read,
    input  logic [4:0] mem_rd,
    input  logic       mem_reg_write,
    input  logic [4:0] wb_rd,
    input  logic       wb_reg_write,
    output logic       stall,
    output fwd_sel_e   fwd_a,
    output fwd_sel_e   fwd_b
);

    // Newest producer wins
    function automatic fwd_sel_e pick(input logic [4:0] rs);
        if (mem_reg_write && mem_rd != 5'd0 && mem_rd == rs)
            return fwd_ex_mem;
        if (wb_reg_write && wb_rd != 5'd0 && wb_rd == rs)
            return fwd_mem_wb;
        return fwd_none;
    endfunction

    always_comb begin
        stall = ex_mem_read && ex_rd != 5'd0 && (ex_rd == id_rs1 || ex_rd == id_rs2);
        fwd_a = pick(ex_rs1);
        fwd_b = pick(ex_rs2);
    end

endmodule

// File: design/rv_branch_predictor.sv
module rv_branch_predictor
    import rv_isa_pkg::*, rv_pipe_pkg::*;
(
    input  logic                CLK,
    input  logic                RESET_N,
    input  logic                clear,
    input  logic [pc_width-1:0] id_pc,
    input  rv_inst_u            id_inst,
    input  logic [xlen-1:0]     id_imm,
    input  logic                ex_branch,
    input  logic                ex_taken,
    input  logic                ex_pred_taken,
    input  logic [pc_width-1:0] ex_pc,
    input  logic [pc_width-1:0] ex_target,
    output logic                redirect,
    output logic                pred_taken,
    output logic [pc_width-1:0] redirect_pc,
    output logic                mispredict,
    output logic [pc_width-1:0] correct_pc
);

    logic [1:0]                 counters [2**pred_index_bits];
    logic [pred_index_bits-1:0] id_idx;
    logic [pred_index_bits-1:0] ex_idx;

    assign id_idx = id_pc[pred_index_bits+1:2];
    assign ex_idx = ex_pc[pred_index_bits+1:2];

    assign pred_taken  = id_inst.b.opcode == op_branch && counters[id_idx][1];
    assign redirect    = pred_taken || id_inst.j.opcode == op_jal; // JAL always taken
    assign redirect_pc = id_pc + id_imm[pc_width-1:0];

    assign mispredict = ex_branch && (ex_taken != ex_pred_taken);
    assign correct_pc = ex_taken ? ex_target : ex_pc + pc_width'(4);

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            for (int i = 0; i < 2**pred_index_bits; i++)
                counters[i] <= 2'b01; // Weakly not taken
        end else if (clear) begin
            for (int i = 0; i < 2**pred_index_bits; i++)
                counters[i] <= 2'b01;
        end else if (ex_branch) begin
            if (ex_taken && counters[ex_idx] != 2'b11)
                counters[ex_idx] <= counters[ex_idx] + 2'b01;
            else if (!ex_taken && counters[ex_idx] != 2'b00)
                counters[ex_idx] <= counters[ex_idx] - 2'b01;
        end
    end

endmodule

// File: design/rv_core.sv
module rv_core
    import rv_isa_pkg::*, rv_pipe_pkg::*;
(
    input  logic                CLK,
    input  logic                RESET_N,
    input  logic                clear,
    input  logic [xlen-1:0]     idata,
    output logic [pc_width-3:0] iaddr,
    output logic [pc_width-3:0] daddr,
    output logic [xlen-1:0]     ddata_w,
    input  logic [xlen-1:0]     ddata_r,
    output logic                mem_write,
    output logic                mem_read,
    output logic                reg_write_enable,
    output logic [4:0]          write_register,
    output logic [xlen-1:0]     reg_write_data
);

    logic [pc_width-1:0] pc;
    if_id_t              if_id;
    id_ex_t              id_ex;
    ex_mem_t             ex_mem;
    mem_wb_t             mem_wb;

    ctrl_t               id_ctrl;
    logic [xlen-1:0]     id_imm, rdata1, rdata2;
    logic                stall, redirect, pred_taken, mispredict, ex_taken, alu_zero;
    fwd_sel_e            fwd_a, fwd_b;
    logic [pc_width-1:0] redirect_pc, correct_pc, ex_pc4;
    logic [xlen-1:0]     op_a, op_b, alu_b, alu_out, ex_result, wb_data;

    function automatic logic [xlen-1:0] fwd_mux(input fwd_sel_e sel, input logic [xlen-1:0] v);
        case (sel)
            fwd_ex_mem: return ex_mem.alu_result;
            fwd_mem_wb: return wb_data;
            default:    return v;
        endcase
    endfunction

    // Fetch; mispredict beats stall, stall beats redirect
    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N)
            pc <= '0;
        else if (mispredict)
            pc <= correct_pc;
        else if (!stall)
            pc <= redirect ? redirect_pc : pc + pc_width'(4);
    end

    assign iaddr = pc[pc_width-1:2];

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N)
            if_id <= '0;
        else if (clear || mispredict || (redirect && !stall))
            if_id <= '0; // Opcode zero decodes as a no-op
        else if (!stall)
            if_id <= '{pc: pc, inst: idata};
    end

    rv_decoder i_decoder (.inst(if_id.inst), .ctrl(id_ctrl), .imm(id_imm));

    rv_regfile i_regfile (
        .CLK(CLK), .RESET_N(RESET_N),
        .rs1(if_id.inst.r.rs1), .rs2(if_id.inst.r.rs2), .rd(mem_wb.rd),
        .wdata(wb_data), .we(mem_wb.ctrl.reg_write),
        .rdata1(rdata1), .rdata2(rdata2)
    );

    rv_hazard_unit i_hazard (
        .id_rs1(if_id.inst.r.rs1), .id_rs2(if_id.inst.r.rs2),
        .ex_rs1(id_ex.rs1), .ex_rs2(id_ex.rs2),
        .ex_rd(id_ex.rd), .ex_mem_read(id_ex.ctrl.mem_read),
        .mem_rd(ex_mem.rd), .mem_reg_write(ex_mem.ctrl.reg_write),
        .wb_rd(mem_wb.rd), .wb_reg_write(mem_wb.ctrl.reg_write),
        .stall(stall), .fwd_a(fwd_a), .fwd_b(fwd_b)
    );

    rv_branch_predictor i_predictor (
        .CLK(CLK), .RESET_N(RESET_N), .clear(clear),
        .id_pc(if_id.pc), .id_inst(if_id.inst), .id_imm(id_imm),
        .ex_branch(id_ex.ctrl.branch), .ex_taken(ex_taken),
        .ex_pred_taken(id_ex.pred_taken), .ex_pc(id_ex.pc), .ex_target(id_ex.pred_target),
        .redirect(redirect), .pred_taken(pred_taken), .redirect_pc(redirect_pc),
        .mispredict(mispredict), .correct_pc(correct_pc)
    );

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N)
            id_ex <= '0;
        else if (clear || mispredict || stall)
            id_ex <= '0; // Bubble
        else
            id_ex <= '{pc: if_id.pc, rs1_val: rdata1, rs2_val: rdata2, imm: id_imm,
                       rs1: if_id.inst.r.rs1, rs2: if_id.inst.r.rs2, rd: if_id.inst.r.rd,
                       funct3: if_id.inst.r.funct3, pred_taken: pred_taken,
                       pred_target: redirect_pc, ctrl: id_ctrl};
    end

    always_comb begin
        op_a   = fwd_mux(fwd_a, id_ex.rs1_val);
        op_b   = fwd_mux(fwd_b, id_ex.rs2_val);
        alu_b  = id_ex.ctrl.alu_src ? id_ex.imm : op_b;
        ex_pc4 = id_ex.pc + pc_width'(4);
        ex_result = id_ex.ctrl.jump ? xlen'(ex_pc4) : alu_out;
        ex_taken  = (id_ex.funct3 == f3_bne) ? !alu_zero : alu_zero;
    end

    rv_alu i_alu (.a(op_a), .b(alu_b), .op(id_ex.ctrl.alu_op), .result(alu_out), .zero(alu_zero));

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N)
            ex_mem <= '0;
        else if (clear)
            ex_mem <= '0;
        else
            ex_mem <= '{alu_result: ex_result, store_data: op_b, rd: id_ex.rd, ctrl: id_ex.ctrl};
    end

    assign daddr     = ex_mem.alu_result[pc_width-1:2];
    assign ddata_w   = ex_mem.store_data;
    assign mem_write = ex_mem.ctrl.mem_write;
    assign mem_read  = ex_mem.ctrl.mem_read;

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N)
            mem_wb <= '0;
        else if (clear)
            mem_wb <= '0;
        else
            mem_wb <= '{alu_result: ex_mem.alu_result, mem_data: ddata_r,
                        rd: ex_mem.rd, ctrl: ex_mem.ctrl};
    end

    assign wb_data          = (mem_wb.ctrl.wb_sel == wb_mem) ? mem_wb.mem_data : mem_wb.alu_result;
    assign reg_write_enable = mem_wb.ctrl.reg_write;
    assign write_register   = mem_wb.rd;
    assign reg_write_data   = wb_data;

endmodule

// File: verif/tb_clock.sv
module tb_clock (
    output logic CLK
);

    localparam int half_period = 10;

    initial begin
        CLK = 1'b0;
        forever #half_period CLK = ~CLK;
    end

endmodule

// File: verif/rv_core_assert.sv
module rv_core_assert
    import rv_pipe_pkg::*;
(
    input logic                CLK,
    input logic                RESET_N,
    input logic                clear,
    input logic                mem_read,
    input logic                mem_write,
    input logic                reg_write_enable,
    input logic [4:0]          write_register,
    input logic                stall,
    input logic                mispredict,
    input logic [pc_width-1:0] pc
);

    int fail_count = 0; // Polled by the testbench monitor

    mem_exclusive: assert property (@(posedge CLK) disable iff (!RESET_N)
        !(mem_read && mem_write))
        else begin
            $error("mem_read and mem_write high in the same cycle");
            fail_count++;
        end

    no_x0_write: assert property (@(posedge CLK) disable iff (!RESET_N)
        reg_write_enable |-> write_register != 5'd0)
        else begin
            $error("writeback shows register x0");
            fail_count++;
        end

    // Stall freezes fetch unless execute redirects
    stall_holds_pc: assert property (@(posedge CLK) disable iff (!RESET_N)
        stall && !mispredict |=> pc == $past(pc))
        else begin
            $error("PC moved during a stall");
            fail_count++;
        end

    clear_no_store: assert property (@(posedge CLK) disable iff (!RESET_N)
        clear |=> !mem_write)
        else begin
            $error("store issued in the cycle after clear");
            fail_count++;
        end

endmodule

// File: verif/tb_rv_core.sv
module tb_rv_core
    import rv_isa_pkg::*, rv_pipe_pkg::*;
();

    localparam int mem_words     = 2**(pc_width-2);
    localparam int first_writes  = 13; // Retired before clear
    localparam int clear_cycles  = 3;
    localparam int reset_cycles  = 10;
    localparam int event_timeout = 40; // Cycles between two retirements
    localparam int drain_cycles  = 20;

    typedef struct packed {
        logic [4:0]      rd;
        logic [xlen-1:0] value;
    } wb_entry_t;

    typedef struct packed {
        logic [pc_width-3:0] addr;
        logic [xlen-1:0]     data;
    } mem_word_t;

    logic                CLK;
    logic                RESET_N;
    logic                clear;
    logic [xlen-1:0]     idata;
    logic [pc_width-3:0] iaddr;
    logic [pc_width-3:0] daddr;
    logic [xlen-1:0]     ddata_w;
    logic [xlen-1:0]     ddata_r;
    logic                mem_write;
    logic                mem_read;
    logic                reg_write_enable;
    logic [4:0]          write_register;
    logic [xlen-1:0]     reg_write_data;

    logic [xlen-1:0] imem [mem_words];
    logic [xlen-1:0] dmem [mem_words];
    logic [xlen-1:0] prog [$];
    mem_word_t       d_all [$];
    wb_entry_t       w_all [$];
    wb_entry_t       w_q [$];
    mem_word_t       s_all [$];
    mem_word_t       s_q [$];
    int              n_writes;
    int              n_events;

    tb_clock i_clock (.CLK(CLK));

    rv_core i_dut (
        .CLK(CLK), .RESET_N(RESET_N), .clear(clear),
        .idata(idata), .iaddr(iaddr),
        .daddr(daddr), .ddata_w(ddata_w), .ddata_r(ddata_r),
        .mem_write(mem_write), .mem_read(mem_read),
        .reg_write_enable(reg_write_enable), .write_register(write_register),
        .reg_write_data(reg_write_data)
    );

    bind rv_core rv_core_assert i_assert (
        .CLK(CLK), .RESET_N(RESET_N), .clear(clear),
        .mem_read(mem_read), .mem_write(mem_write),
        .reg_write_enable(reg_write_enable), .write_register(write_register),
        .stall(stall), .mispredict(mispredict), .pc(pc)
    );

    // Memories update half a cycle after the addresses settle
    always @(negedge CLK) begin
        if (mem_write)
            dmem[daddr] = ddata_w;
        idata   = imem[iaddr];
        ddata_r = mem_read ? dmem[daddr] : 'x; // Valid only during a load
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [xlen-1:0] got,
                               input logic [xlen-1:0] exp);
        if (got !== exp)
            stop_with_failure($sformatf("ERROR: time %0t signal %s got %h expected %h",
                                        $time, name, got, exp));
    endtask

    task automatic load_trace();
        int          fd;
        int          n;
        string       tag;
        string       rest;
        logic [31:0] a;
        logic [31:0] b;
        fd = $fopen("verif/core_trace.txt", "r");
        if (fd == 0)
            stop_with_failure("cannot open verif/core_trace.txt");
        while ($fscanf(fd, "%s", tag) == 1) begin
            if (tag == "#") begin
                n = $fgets(rest, fd);
            end else if (tag == "I") begin
                n = $fscanf(fd, "%h", a);
                prog.push_back(a);
            end else if (tag == "D") begin
                n = $fscanf(fd, "%h %h", a, b);
                d_all.push_back('{addr: a[pc_width-3:0], data: b});
            end else if (tag == "W") begin
                n = $fscanf(fd, "%h %h", a, b);
                w_all.push_back('{rd: a[4:0], value: b});
            end else if (tag == "S") begin
                n = $fscanf(fd, "%h %h", a, b);
                s_all.push_back('{addr: a[pc_width-3:0], data: b});
            end else begin
                stop_with_failure($sformatf("unknown tag %s in the trace file", tag));
            end
        end
        $fclose(fd);
    endtask

    task automatic init_memories();
        for (int a = 0; a < mem_words; a++) begin
            imem[a] = {a[pc_width-3:0], 22'h0}; // Opcode zero decodes as a bubble
            dmem[a] = {12'hdad, a[pc_width-3:0], a[pc_width-3:0]};
        end
        foreach (prog[i])
            imem[i] = prog[i];
        foreach (d_all[i])
            dmem[d_all[i].addr] = d_all[i].data;
    endtask

    task automatic restart_queues();
        w_q      = w_all;
        s_q      = s_all;
        n_writes = 0;
    endtask

    task automatic apply_reset();
        RESET_N = 1'b0;
        clear   = 1'b0;
        init_memories();
        repeat (reset_cycles) @(negedge CLK);
        RESET_N = 1'b1;
    endtask

    // Checks retirements and stores once per falling edge
    task automatic check_events();
        wb_entry_t w;
        mem_word_t s;
        if (i_dut.i_assert.fail_count != 0)
            stop_with_failure("a concurrent assertion on the core failed");
        if (reg_write_enable) begin
            if (w_q.size() == 0)
                stop_with_failure($sformatf("unexpected writeback to x%0d at time %0t",
                                            write_register, $time));
            w = w_q.pop_front();
            check_value("write_register", write_register, w.rd);
            check_value("reg_write_data", reg_write_data, w.value);
            n_writes++;
            n_events++;
        end
        if (mem_write) begin
            if (s_q.size() == 0)
                stop_with_failure($sformatf("unexpected store to word %h at time %0t",
                                            daddr, $time));
            s = s_q.pop_front();
            check_value("daddr", daddr, s.addr);
            check_value("ddata_w", ddata_w, s.data);
            n_events++;
        end
    endtask

    // A negative target waits until both queues are empty
    task automatic run_until(input int w_target);
        int idle;
        int seen;
        idle = 0;
        seen = n_events;
        while ((w_target >= 0) ? (n_writes < w_target) : (w_q.size() + s_q.size() != 0)) begin
            @(negedge CLK);
            check_events();
            if (n_events != seen) begin
                seen = n_events;
                idle = 0;
            end else begin
                idle++;
                if (idle > event_timeout && w_q.size() != 0)
                    stop_with_failure($sformatf("timeout, writeback of %h to x%0d never came",
                                                w_q[0].value, w_q[0].rd));
                else if (idle > event_timeout)
                    stop_with_failure($sformatf("timeout, store of %h to word %h never came",
                                                s_q[0].data, s_q[0].addr));
            end
        end
    endtask

    initial begin
        RESET_N  = 1'b0;
        clear    = 1'b0;
        idata    = '0;
        ddata_r  = '0;
        n_events = 0;
        load_trace();
        restart_queues();
        apply_reset();
        run_until(first_writes);

        clear = 1'b1; // Store in execute must not reach memory
        repeat (clear_cycles) begin
            @(negedge CLK);
            check_value("reg_write_enable", reg_write_enable, 1'b0);
            check_value("mem_write", mem_write, 1'b0);
            check_value("mem_read", mem_read, 1'b0);
        end

        apply_reset();
        restart_queues(); // Replay from address zero
        run_until(-1);
        repeat (drain_cycles) begin
            @(negedge CLK);
            check_events();
        end
        $display("Everything OK");
        $finish;
    end

endmodule

// File: verif/core_trace.txt
# I: instruction word, in address order from 0 | D: word address, initial data
# W: expected rd, value | S: expected store word address, data
I 00500093
I FFD00113
I 002081B3
I 40118233
I 001122B3
I FFF0A313
I 123453B7
I 6783E393
I 0023C433
I 0F047493
I 00700013
I FFF14513
I 00A4E5B3
I 0020A633
I 10000693
I 0076A423
I 0086A703
I 001707B3
I 0006A803
I 0106A223
I 00000893
I 00188893
I FF089EE3
I 01088913
I 00090463
I 05500993
I 01398463
I 7FF00A13
I 00198A93
I 00C00B6F
I 6AA00A13
I 0136A023
I 015B0BB3
I 0176A623
I 0000006F
D 040 00000003
D 042 DEADBEEF
W 01 00000005
W 02 FFFFFFFD
W 03 00000002
W 04 FFFFFFFD
W 05 00000001
W 06 00000000
W 07 12345000
W 07 12345678
W 08 EDCBA985
W 09 00000080
W 0A 00000002
W 0B 00000082
W 0C 00000000
W 0D 00000100
W 0E 12345678
W 0F 1234567D
W 10 00000003
W 11 00000000
W 11 00000001
W 11 00000002
W 11 00000003
W 12 00000013
W 13 00000055
W 15 00000056
W 16 00000078
W 17 000000CE
S 042 12345678
S 041 00000003
S 043 000000CE

// File: compile.f
design/rv_isa_pkg.sv
design/rv_pipe_pkg.sv
design/rv_decoder.sv
design/rv_regfile.sv
design/rv_alu.sv
design/rv_hazard_unit.sv
design/rv_branch_predictor.sv
design/rv_core.sv
verif/tb_clock.sv
verif/rv_core_assert.sv
verif/tb_rv_core.sv

// File: Bender.yml
package:
  name: rv_core

sources:
  - design/rv_isa_pkg.sv
  - design/rv_pipe_pkg.sv
  - design/rv_decoder.sv
  - design/rv_regfile.sv
  - design/rv_alu.sv
  - design/rv_hazard_unit.sv
  - design/rv_branch_predictor.sv
  - design/rv_core.sv
  - target: test
    files:
      - verif/tb_clock.sv
      - verif/rv_core_assert.sv
      - verif/tb_rv_core.sv
